// ==== filelist.f ====
logic/slc3_isa_pkg.sv
logic/slc3_ctrl_pkg.sv
logic/control_sequencer.sv
logic/control_word_gen.sv
logic/slc3_control.sv
tb/slc3_control_checker.sv
tb/tb_slc3_control.sv

// ==== logic/control_sequencer.sv ====
// ----------------------------------------
// SLC-3 sequencer FSM
// state register, memory wait counter
// and next-state decode
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_sequencer (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 run_i,      // leave halted
	input  wire logic                 continue_i, // pse handshake
	input  wire logic                 ben_i,      // branch enable from datapath
	input  wire slc3_isa_pkg::instr_t ir_i,
	output slc3_ctrl_pkg::state_e     state_o
);

	import slc3_isa_pkg::*;
	import slc3_ctrl_pkg::*;

	state_e state;
	state_e state_nxt;

	logic [WAIT_CNT_W-1:0] wait_cnt; // cycles spent in current wait state
	logic                  wait_done;

	// states that hold a bram access open
	function automatic logic is_wait(input state_e s);
		return s inside {st_fetch_wait, st_ldr_wait, st_str_wait};
	endfunction

	assign wait_done = (wait_cnt == WAIT_LAST);
	assign state_o = state;

	// ----------------------------------------
	// state register
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_halted;
		else
			state <= state_nxt;
	end

	// wait counter, restarts on each wait entry
	always_ff @(posedge clk)
	begin
		if (reset)
			wait_cnt <= '0;
		else if (is_wait(state_nxt) && (state_nxt != state))
			wait_cnt <= '0;
		else if (is_wait(state))
			wait_cnt <= wait_cnt + 1'b1; // last bump on exit is harmless
	end

	// ----------------------------------------
	// next state
	always_comb
	begin
		state_nxt = state; // hold unless told otherwise

		case (state)
			st_halted:
				if (run_i)
					state_nxt = st_fetch_mar;

			// fetch
			st_fetch_mar:  state_nxt = st_fetch_wait;
			st_fetch_wait:
				if (wait_done)
					state_nxt = st_fetch_ir;
			st_fetch_ir:   state_nxt = st_decode;

			// ir is valid here, ben loads alongside
			st_decode:
			begin
				case (ir_i.opcode)
					op_add:  state_nxt = ir_i.imm_flag ? st_addi : st_add;
					op_and:  state_nxt = ir_i.imm_flag ? st_andi : st_and;
					op_not:  state_nxt = st_not;
					op_ldr:  state_nxt = st_ldr_addr;
					op_str:  state_nxt = st_str_addr;
					op_jsr:  state_nxt = st_jsr_link;
					op_jmp:  state_nxt = st_jmp;
					op_br:   state_nxt = st_br;
					op_pse:  state_nxt = st_pause_1;
					default: state_nxt = st_fetch_mar; // unknown, skip it
				endcase
			end

			// single cycle ops
			st_add, st_addi, st_and, st_andi, st_not, st_jmp:
				state_nxt = st_fetch_mar;

			// ldr: address, wait, write back
			st_ldr_addr:   state_nxt = st_ldr_wait;
			st_ldr_wait:
				if (wait_done)
					state_nxt = st_ldr_wb;
			st_ldr_wb:     state_nxt = st_fetch_mar;

			// str: address, data, write wait
			st_str_addr:   state_nxt = st_str_data;
			st_str_data:   state_nxt = st_str_wait;
			st_str_wait:
				if (wait_done)
					state_nxt = st_fetch_mar;

			// jsr: save pc, then jump
			st_jsr_link:   state_nxt = st_jsr_jump;
			st_jsr_jump:   state_nxt = st_fetch_mar;

			st_br:         state_nxt = ben_i ? st_br_taken : st_fetch_mar;
			st_br_taken:   state_nxt = st_fetch_mar;

			// wait for continue high, then low again
			st_pause_1:
				if (continue_i)
					state_nxt = st_pause_2;
			st_pause_2:
				if (!continue_i)
					state_nxt = st_fetch_mar;

			default:       state_nxt = st_halted;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/control_word_gen.sv ====
// ----------------------------------------
// SLC-3 control word decode
// Moore outputs, one word per state
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_word_gen (
	input  wire slc3_ctrl_pkg::state_e state_i,
	output slc3_ctrl_pkg::ctrl_word_t  ctrl_o
);

	import slc3_ctrl_pkg::*;

	always_comb
	begin
		ctrl_o = CTRL_IDLE; // everything off, selects at first value

		case (state_i)
			// ----------------------------------------
			// fetch and decode
			st_fetch_mar:
			begin
				ctrl_o.bus_gate = gate_pc; // mar <- pc
				ctrl_o.ld.mar   = 1'b1;
				ctrl_o.pcmux    = pc_inc;  // pc <- pc + 1
				ctrl_o.ld.pc    = 1'b1;
			end
			st_fetch_wait, st_ldr_wait:
			begin
				ctrl_o.mem_ena = 1'b1; // read, mdr catches bram output
				ctrl_o.ld.mdr  = 1'b1;
			end
			st_fetch_ir:
			begin
				ctrl_o.bus_gate = gate_mdr;
				ctrl_o.ld.ir    = 1'b1;
			end
			st_decode: ctrl_o.ld.ben = 1'b1;

			// ----------------------------------------
			// alu ops, dr <- sr1 op sr2/imm5, flags follow
			st_add, st_addi, st_and, st_andi, st_not:
			begin
				ctrl_o.bus_gate    = gate_alu;
				ctrl_o.ld.reg_file = 1'b1;
				ctrl_o.ld.cc       = 1'b1;
				case (state_i)
					st_addi:
					begin
						ctrl_o.aluk    = aluk_add;
						ctrl_o.sr2_imm = 1'b1;
					end
					st_and:  ctrl_o.aluk = aluk_and;
					st_andi:
					begin
						ctrl_o.aluk    = aluk_and;
						ctrl_o.sr2_imm = 1'b1;
					end
					st_not:  ctrl_o.aluk = aluk_not;
					default: ctrl_o.aluk = aluk_add;
				endcase
			end

			// ----------------------------------------
			// memory ops
			st_ldr_addr, st_str_addr:
			begin
				ctrl_o.bus_gate  = gate_marmux; // mar <- base + sext(off6)
				ctrl_o.ld.mar    = 1'b1;
				ctrl_o.addr1_sr1 = 1'b1;
				ctrl_o.addr2     = addr2_off6;
			end
			st_ldr_wb:
			begin
				ctrl_o.bus_gate    = gate_mdr;
				ctrl_o.ld.reg_file = 1'b1;
			end
			st_str_data:
			begin
				ctrl_o.bus_gate = gate_alu; // source reg sits in ir[11:9]
				ctrl_o.sr1_hi   = 1'b1;
				ctrl_o.aluk     = aluk_pass;
				ctrl_o.ld.mdr   = 1'b1;
			end
			st_str_wait:
			begin
				ctrl_o.mem_ena = 1'b1;
				ctrl_o.mem_wr  = 1'b1; // held for the whole write
			end

			// ----------------------------------------
			// control flow
			st_jsr_link:
			begin
				ctrl_o.bus_gate    = gate_pc; // r7 <- incremented pc
				ctrl_o.dr_r7       = 1'b1;
				ctrl_o.ld.reg_file = 1'b1;
			end
			st_jsr_jump:
			begin
				ctrl_o.pcmux = pc_adder; // pc + sext(off11)
				ctrl_o.addr2 = addr2_off11;
				ctrl_o.ld.pc = 1'b1;
			end
			st_jmp:
			begin
				ctrl_o.bus_gate = gate_alu; // base reg through alu
				ctrl_o.aluk     = aluk_pass;
				ctrl_o.pcmux    = pc_bus;
				ctrl_o.ld.pc    = 1'b1;
			end
			st_br_taken:
			begin
				ctrl_o.pcmux = pc_adder; // pc + sext(off9)
				ctrl_o.addr2 = addr2_off9;
				ctrl_o.ld.pc = 1'b1;
			end

			// ir shown on leds while paused
			st_pause_1, st_pause_2: ctrl_o.ld.led = 1'b1;

			default: ctrl_o = CTRL_IDLE; // halted, br not taken
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/slc3_control.sv ====
// ----------------------------------------
// SLC-3 ISDU top
// sequencer feeding the control word decode
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slc3_control (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 run_i,
	input  wire logic                 continue_i,
	input  wire logic                 ben_i,
	input  wire slc3_isa_pkg::instr_t ir_i,
	output slc3_ctrl_pkg::ctrl_word_t ctrl_o
);

	import slc3_ctrl_pkg::*;

	state_e state; // registered, so ctrl_o is glitch free per state

	control_sequencer i_control_sequencer (
		.clk        (clk),
		.reset      (reset),
		.run_i      (run_i),
		.continue_i (continue_i),
		.ben_i      (ben_i),
		.ir_i       (ir_i),
		.state_o    (state)
	);

	control_word_gen i_control_word_gen (
		.state_i (state),
		.ctrl_o  (ctrl_o)
	);

endmodule

`default_nettype wire

// ==== logic/slc3_ctrl_pkg.sv ====
// ----------------------------------------
// SLC-3 control unit definitions
// states, datapath selects, control word
// ----------------------------------------
`default_nettype none

package slc3_ctrl_pkg;

	// ----------------------------------------
	// memory timing
	// sync bram plus output register
	localparam int MEM_WAIT_CYCLES = 3;
	localparam int WAIT_CNT_W = $clog2(MEM_WAIT_CYCLES + 1);
	localparam logic [WAIT_CNT_W-1:0] WAIT_LAST = WAIT_CNT_W'(MEM_WAIT_CYCLES - 1);

	// ----------------------------------------
	// sequencer states
	typedef enum logic [4:0] {
		st_halted,
		// fetch and decode
		st_fetch_mar,
		st_fetch_wait,
		st_fetch_ir,
		st_decode,
		// alu ops
		st_add,
		st_addi,
		st_and,
		st_andi,
		st_not,
		// memory ops
		st_ldr_addr,
		st_ldr_wait,
		st_ldr_wb,
		st_str_addr,
		st_str_data,
		st_str_wait,
		// control flow
		st_jsr_link,
		st_jsr_jump,
		st_jmp,
		st_br,
		st_br_taken,
		// pse handshake
		st_pause_1,
		st_pause_2
	} state_e;

	// ----------------------------------------
	// datapath mux selects
	typedef enum logic [1:0] {pc_inc, pc_adder, pc_bus} pcmux_e;
	typedef enum logic [1:0] {addr2_zero, addr2_off6, addr2_off9, addr2_off11} addr2_e;
	typedef enum logic [1:0] {aluk_add, aluk_and, aluk_pass, aluk_not} aluk_e;

	// one driver on the shared bus at a time
	typedef enum logic [2:0] {gate_none, gate_mdr, gate_alu, gate_pc, gate_marmux} bus_gate_e;

	// register load strobes
	typedef struct packed {
		logic mar;
		logic mdr;
		logic ir;
		logic pc;
		logic reg_file; // register file write
		logic cc;       // nzp flags
		logic ben;
		logic led;
	} ld_t;

	// full control word seen by the datapath
	typedef struct packed {
		ld_t       ld;
		logic      mem_ena;   // bram access
		logic      mem_wr;    // write, only with mem_ena
		pcmux_e    pcmux;
		addr2_e    addr2;
		aluk_e     aluk;
		bus_gate_e bus_gate;
		logic      addr1_sr1; // addr1 from sr1, else pc
		logic      sr1_hi;    // sr1 from ir[11:9], else ir[8:6]
		logic      dr_r7;     // dest is r7, else ir[11:9]
		logic      sr2_imm;   // sext imm5 into alu b
	} ctrl_word_t;

	// nothing loads, nothing drives the bus
	localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

`default_nettype wire

// ==== logic/slc3_isa_pkg.sv ====
// ----------------------------------------
// SLC-3 instruction set definitions
// word layout and opcode encoding
// ----------------------------------------
`default_nettype none

package slc3_isa_pkg;

	// ----------------------------------------
	// word size
	localparam int WORD_W = 16; // data and instruction width

	// link register written by jsr
	localparam logic [2:0] REG_R7 = 3'd7;

	// ----------------------------------------
	// opcodes, lc-3 encoding
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_jsr = 4'b0100,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_pse = 4'b1101 // pause, shows ir on leds
	} opcode_e;

	// instruction word, msb first
	typedef struct packed {
		opcode_e    opcode;   // [15:12]
		logic [2:0] dr;       // [11:9] dest, or source for str
		logic [2:0] sr1;      // [8:6] source / base register
		logic       imm_flag; // [5] imm5 form of add and and
		logic [4:0] low;      // [4:0] sr2 / imm5 / offset bits
	} instr_t;

endpackage

`default_nettype wire

// ==== tb/slc3_control_checker.sv ====
// ----------------------------------------
// SLC-3 control checker
// fetch, decode and memory strobe rules
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slc3_control_checker (
	input wire logic                      clk,
	input wire logic                      reset,
	input wire slc3_ctrl_pkg::ctrl_word_t ctrl_i
);

	// ----------------------------------------
	// fetch and decode ordering
	// ir load always hands over to decode
	ir_then_ben: assert property (
		@(posedge clk) disable iff (reset)
		ctrl_i.ld.ir |=> ctrl_i.ld.ben
	) else $error("ld ir was not followed by ld ben");

	// decode only straight after the ir load
	ben_after_ir: assert property (
		@(posedge clk) disable iff (reset)
		ctrl_i.ld.ben |-> $past(ctrl_i.ld.ir)
	) else $error("ld ben seen without ld ir in the cycle before");

	// ----------------------------------------
	// memory strobes
	wr_needs_ena: assert property (
		@(posedge clk) disable iff (reset)
		ctrl_i.mem_wr |-> ctrl_i.mem_ena
	) else $error("mem_wr asserted without mem_ena");

	// mar must stay put during an access
	mar_quiet_in_access: assert property (
		@(posedge clk) disable iff (reset)
		!(ctrl_i.ld.mar && ctrl_i.mem_ena)
	) else $error("ld mar asserted during a memory access");

endmodule

`default_nettype wire

// ==== tb/tb_slc3_control.sv ====
// ----------------------------------------
// SLC-3 ISDU testbench
// instruction table through fetch, decode
// and execute, control words checked
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_slc3_control;

	import slc3_isa_pkg::*;
	import slc3_ctrl_pkg::*;

	// ----------------------------------------
	// test sizing
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 4; // halted cycles before run
	localparam int FETCH_LEN    = 1 + MEM_WAIT_CYCLES + 1 + 1;
	localparam int N_ROWS       = 13;
	localparam int PAUSE_LOW    = 3; // continue low cycles in pause
	localparam int PAUSE_HIGH   = 2; // then high for this many

	// load strobe bits, mar is the msb
	localparam logic [7:0] LD_MAR = 8'b1000_0000;
	localparam logic [7:0] LD_MDR = 8'b0100_0000;
	localparam logic [7:0] LD_IR  = 8'b0010_0000;
	localparam logic [7:0] LD_PC  = 8'b0001_0000;
	localparam logic [7:0] LD_REG = 8'b0000_1000;
	localparam logic [7:0] LD_CC  = 8'b0000_0100;
	localparam logic [7:0] LD_BEN = 8'b0000_0010;
	localparam logic [7:0] LD_LED = 8'b0000_0001;

	// select bits {addr1_sr1, sr1_hi, dr_r7, sr2_imm}
	localparam logic [3:0] SEL_ADDR1 = 4'b1000;
	localparam logic [3:0] SEL_SR1HI = 4'b0100;
	localparam logic [3:0] SEL_R7    = 4'b0010;
	localparam logic [3:0] SEL_IMM   = 4'b0001;

	logic       clk = 1'b0;
	logic       reset;
	logic       run_i;
	logic       continue_i;
	logic       ben_i;
	instr_t     ir_i;
	ctrl_word_t ctrl_o;

	// instruction table columns
	logic [15:0] row_instr  [N_ROWS];
	logic        row_ben    [N_ROWS];
	int          row_len    [N_ROWS]; // execute cycles up to next fetch
	ctrl_word_t  row_first  [N_ROWS];
	ctrl_word_t  row_second [N_ROWS];
	ctrl_word_t  row_last   [N_ROWS];
	int          order      [N_ROWS];

	ctrl_word_t fetch_word;
	ctrl_word_t wait_word;
	ctrl_word_t ir_word;
	ctrl_word_t decode_word;

	integer seed        = 32'hfc379993;
	int     err_cnt     = 0;
	int     cycle_cnt   = 0;
	int     cycle_limit = 100000; // replaced once the table is known

	slc3_control i_slc3_control (
		.clk        (clk),
		.reset      (reset),
		.run_i      (run_i),
		.continue_i (continue_i),
		.ben_i      (ben_i),
		.ir_i       (ir_i),
		.ctrl_o     (ctrl_o)
	);

	bind slc3_control slc3_control_checker i_slc3_control_checker (
		.clk    (clk),
		.reset  (reset),
		.ctrl_i (ctrl_o)
	);

	always #10 clk = ~clk; // 20 ns period

	// ----------------------------------------
	// run length guard
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// build an expected word field by field
	function automatic ctrl_word_t make_word(input logic [7:0] ld, input logic [1:0] mem,
		input pcmux_e pcmux, input addr2_e addr2, input aluk_e aluk,
		input bus_gate_e gate, input logic [3:0] sel);
		ctrl_word_t w;
		w = '0;
		w.ld = ld;
		{w.mem_ena, w.mem_wr} = mem; // {ena, wr}
		w.pcmux = pcmux;
		w.addr2 = addr2;
		w.aluk = aluk;
		w.bus_gate = gate;
		{w.addr1_sr1, w.sr1_hi, w.dr_r7, w.sr2_imm} = sel;
		return w;
	endfunction

	// fetch_mar is the only state loading mar and pc together
	function automatic logic fetch_started(input ctrl_word_t w);
		return w.ld.mar && w.ld.pc;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
				$time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic tick;
		@(posedge clk);
		@(negedge clk); // outputs settled mid cycle
	endtask

	// second word defaults to the last, memory rows override it
	task automatic set_row(input int idx, input logic [15:0] instr, input logic ben,
		input int len, input ctrl_word_t first, input ctrl_word_t last);
		row_instr[idx]  = instr;
		row_ben[idx]    = ben;
		row_len[idx]    = len;
		row_first[idx]  = first;
		row_second[idx] = last;
		row_last[idx]   = last;
	endtask

	// ----------------------------------------
	// instruction table
	task automatic load_table;
		ctrl_word_t w_add;
		ctrl_word_t w_addr;
		ctrl_word_t w_led;
		int         total;
		fetch_word  = make_word(LD_MAR | LD_PC, 2'b00, pc_inc, addr2_zero, aluk_add, gate_pc, 0);
		wait_word   = make_word(LD_MDR, 2'b10, pc_inc, addr2_zero, aluk_add, gate_none, 0);
		ir_word     = make_word(LD_IR, 2'b00, pc_inc, addr2_zero, aluk_add, gate_mdr, 0);
		decode_word = make_word(LD_BEN, 2'b00, pc_inc, addr2_zero, aluk_add, gate_none, 0);
		w_add  = make_word(LD_REG | LD_CC, 2'b00, pc_inc, addr2_zero, aluk_add, gate_alu, 0);
		w_addr = make_word(LD_MAR, 2'b00, pc_inc, addr2_off6, aluk_add, gate_marmux, SEL_ADDR1);
		w_led  = make_word(LD_LED, 2'b00, pc_inc, addr2_zero, aluk_add, gate_none, 0);

		// alu, register and immediate forms
		set_row(0, {op_add, 3'd1, 3'd2, 1'b0, 5'd3}, 1'b0, 1, w_add, w_add);
		w_add.sr2_imm = 1'b1;
		set_row(1, {op_add, 3'd1, 3'd2, 1'b1, 5'd7}, 1'b0, 1, w_add, w_add);
		w_add.sr2_imm = 1'b0;
		w_add.aluk = aluk_and;
		set_row(2, {op_and, 3'd4, 3'd5, 1'b0, 5'd6}, 1'b0, 1, w_add, w_add);
		w_add.sr2_imm = 1'b1;
		set_row(3, {op_and, 3'd4, 3'd5, 1'b1, 5'h1f}, 1'b0, 1, w_add, w_add);
		w_add.sr2_imm = 1'b0;
		w_add.aluk = aluk_not;
		set_row(4, {op_not, 3'd3, 3'd1, 6'h3f}, 1'b0, 1, w_add, w_add);
		// memory: address, wait, write back or data, wait
		set_row(5, {op_ldr, 3'd2, 3'd6, 6'h04}, 1'b0, 1 + MEM_WAIT_CYCLES + 1, w_addr,
			make_word(LD_REG, 2'b00, pc_inc, addr2_zero, aluk_add, gate_mdr, 0));
		row_second[5] = wait_word; // read wait, mdr catches the data
		set_row(6, {op_str, 3'd2, 3'd6, 6'h3e}, 1'b0, 2 + MEM_WAIT_CYCLES, w_addr,
			make_word(8'h00, 2'b11, pc_inc, addr2_zero, aluk_add, gate_none, 0));
		row_second[6] = make_word(LD_MDR, 2'b00, pc_inc, addr2_zero, aluk_pass, gate_alu,
			SEL_SR1HI); // mdr <- source reg
		// control flow
		set_row(7, {op_jsr, 1'b1, 11'h010}, 1'b0, 2,
			make_word(LD_REG, 2'b00, pc_inc, addr2_zero, aluk_add, gate_pc, SEL_R7),
			make_word(LD_PC, 2'b00, pc_adder, addr2_off11, aluk_add, gate_none, 0));
		w_add = make_word(LD_PC, 2'b00, pc_bus, addr2_zero, aluk_pass, gate_alu, 0);
		set_row(8, {op_jmp, 3'd0, 3'd5, 6'd0}, 1'b0, 1, w_add, w_add);
		set_row(9, {op_br, 3'b111, 9'h005}, 1'b0, 1, CTRL_IDLE, CTRL_IDLE); // not taken
		set_row(10, {op_br, 3'b010, 9'h1fc}, 1'b1, 2, CTRL_IDLE,
			make_word(LD_PC, 2'b00, pc_adder, addr2_off9, aluk_add, gate_none, 0));
		// pause_1 while continue low, pause_2 while high, one cycle each edge
		set_row(11, {op_pse, 12'h0a5}, 1'b0, PAUSE_LOW + PAUSE_HIGH + 1, w_led, w_led);
		set_row(12, {4'b1111, 12'h025}, 1'b0, 0, CTRL_IDLE, CTRL_IDLE); // unknown opcode

		total = 0;
		for (int i = 0; i < N_ROWS; i++)
			total += FETCH_LEN + row_len[i];
		cycle_limit = 2 * (RESET_CYCLES + IDLE_CYCLES + 2 + 2 * total);
	endtask

	// ----------------------------------------
	// one instruction, entered on its fetch_mar cycle
	task automatic run_row(input int idx, input int pass);
		int         n;
		int         w;
		logic       done;
		logic       is_pse;
		ctrl_word_t last_word;
		string      tag;
		n = 0;
		done = 1'b0;
		last_word = CTRL_IDLE;
		is_pse = (row_instr[idx][15:12] == op_pse);
		tag = $sformatf("pass %0d row %0d", pass, idx);

		check_eq(ctrl_o, fetch_word, {tag, " fetch mar word"});
		for (w = 0; w < MEM_WAIT_CYCLES; w++)
		begin
			tick();
			check_eq(ctrl_o, wait_word, {tag, " fetch wait word"});
		end
		tick();
		check_eq(ctrl_o, ir_word, {tag, " ir load word"});

		// ir register loads on this edge
		@(posedge clk);
		ir_i  <= row_instr[idx];
		ben_i <= row_ben[idx];
		@(negedge clk);
		check_eq(ctrl_o, decode_word, {tag, " decode word"});

		while (!done)
		begin
			@(posedge clk);
			if (is_pse)
				continue_i <= (n >= PAUSE_LOW) && (n < PAUSE_LOW + PAUSE_HIGH);
			@(negedge clk);
			if (fetch_started(ctrl_o))
				done = 1'b1;
			else
			begin
				if (n == 0)
					check_eq(ctrl_o, row_first[idx], {tag, " first execute word"});
				if (n == 1)
					check_eq(ctrl_o, row_second[idx], {tag, " second execute word"});
				if (is_pse)
					check_eq(ctrl_o.ld.led, 1'b1, {tag, " ld led held in pause"});
				last_word = ctrl_o;
				n++;
			end
		end
		check_eq(n, row_len[idx], {tag, " execute length"});
		if (row_len[idx] > 0)
			check_eq(last_word, row_last[idx], {tag, " last execute word"});
	endtask

	// ----------------------------------------
	// main sequence
	initial
	begin
		int i;
		int j;
		int tmp;
		reset      = 1'b1;
		run_i      = 1'b0;
		continue_i = 1'b0;
		ben_i      = 1'b0;
		ir_i       = '0;
		load_table();

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// halted, nothing moves without run
		repeat (IDLE_CYCLES)
		begin
			tick();
			check_eq(ctrl_o, CTRL_IDLE, "idle while halted");
		end
		@(posedge clk);
		run_i <= 1'b1;
		@(negedge clk);
		check_eq(ctrl_o, CTRL_IDLE, "still halted on the run edge");
		tick();
		check_eq(ctrl_o.ld.mar, 1'b1, "ld mar one cycle after run");
		check_eq(ctrl_o.ld.pc, 1'b1, "ld pc one cycle after run");

		for (i = 0; i < N_ROWS; i++)
			order[i] = i;
		for (i = 0; i < N_ROWS; i++)
			run_row(order[i], 1);

		// second pass, shuffled
		for (i = N_ROWS - 1; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < N_ROWS; i++)
			run_row(order[i], 2);

		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
